//--- build.f
+incdir+sim
rtl/cpu_ops_pkg.sv
rtl/cpu_regs_pkg.sv
rtl/first_byte_decode.sv
rtl/exec_decode.sv
rtl/ctrl_seq.sv
rtl/cpu_ctrl.sv
sim/cpu_ctrl_asserts.sv
sim/cpu_ctrl_tb.sv

//--- rtl/cpu_ctrl.sv
// control sequencer top: first-byte decoder, prefix decoder and sequencer
// the fetch unit advances its window by fetched at each enabled edge
`timescale 1ns/100ps

module cpu_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cen,
    input  logic [cpu_ops_pkg::OP_BYTES*8-1:0]  op,
    input  logic                                op_ok,
    output logic [1:0]                          fetched,
    output logic                                pc_we,
    output logic                                rfp_we,
    output logic                                inc_rfp,
    output logic                                dec_rfp,
    output logic                                flag_we,
    output cpu_ops_pkg::alu_op_t                alu_op,
    output logic [cpu_ops_pkg::IMM_W-1:0]       alu_imm,
    output logic                                alu_smux,
    output logic                                alu_wait,
    output cpu_regs_pkg::we_mask_t              regs_we,
    output cpu_regs_pkg::reg_code_t             regs_dst,
    output cpu_regs_pkg::reg_code_t             regs_src
);
    cpu_ops_pkg::op_class_t   fd_class;
    cpu_regs_pkg::size_t      fd_size, latched_size;
    cpu_regs_pkg::reg_code_t  fd_reg, prefix_reg, ex_src, ex_dst;
    logic [7:0]               fd_imm;
    logic [1:0]               fd_len;
    cpu_ops_pkg::alu_op_t     ex_alu_op;
    cpu_regs_pkg::we_mask_t   ex_we;
    logic                     ex_use_imm3, ex_sets_flags, ex_legal;

    first_byte_decode first_byte_decode_inst (
        .op       (op[15:0]),
        .op_class (fd_class),
        .size     (fd_size),
        .reg_code (fd_reg),
        .byte_imm (fd_imm),
        .length   (fd_len)
    );

    exec_decode exec_decode_inst (
        .op         (op[7:0]),
        .size       (latched_size),
        .prefix_reg (prefix_reg),
        .alu_op     (ex_alu_op),
        .src        (ex_src),
        .dst        (ex_dst),
        .we         (ex_we),
        .use_imm3   (ex_use_imm3),
        .sets_flags (ex_sets_flags),
        .legal      (ex_legal)
    );

    ctrl_seq ctrl_seq_inst (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .op_ok         (op_ok),
        .op            (op),
        .fd_class      (fd_class),
        .fd_size       (fd_size),
        .fd_reg        (fd_reg),
        .fd_imm        (fd_imm),
        .fd_len        (fd_len),
        .ex_alu_op     (ex_alu_op),
        .ex_src        (ex_src),
        .ex_dst        (ex_dst),
        .ex_we         (ex_we),
        .ex_use_imm3   (ex_use_imm3),
        .ex_sets_flags (ex_sets_flags),
        .ex_legal      (ex_legal),
        .fetched       (fetched),
        .latched_size  (latched_size),
        .prefix_reg    (prefix_reg),
        .pc_we         (pc_we),
        .rfp_we        (rfp_we),
        .inc_rfp       (inc_rfp),
        .dec_rfp       (dec_rfp),
        .flag_we       (flag_we),
        .alu_op        (alu_op),
        .alu_imm       (alu_imm),
        .alu_smux      (alu_smux),
        .alu_wait      (alu_wait),
        .regs_we       (regs_we),
        .regs_dst      (regs_dst),
        .regs_src      (regs_src)
    );

endmodule

//--- rtl/cpu_ops_pkg.sv
// operation encodings shared by the decoders, the sequencer and the testbench
// covers ALU commands, sequencer phases and first-byte instruction classes
package cpu_ops_pkg;

    localparam int OP_BYTES = 4;   // opcode window width in bytes
    localparam int IMM_W    = 32;  // ALU immediate width

    // command sent to the ALU with each register or flag write
    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1,
        ALU_CCF  = 6'd2,
        ALU_ADD  = 6'd3,
        ALU_ADC  = 6'd4,
        ALU_SUB  = 6'd5,
        ALU_SBC  = 6'd6,
        ALU_AND  = 6'd7,
        ALU_XOR  = 6'd8,
        ALU_OR   = 6'd9,
        ALU_CP   = 6'd10,
        ALU_CPL  = 6'd11,
        ALU_NEG  = 6'd12
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH    = 2'd0,  // decode first byte
        EXEC     = 2'd1,  // second byte of a prefixed op
        FILL_IMM = 2'd2   // upper immediate bytes
    } phase_t;

    // what the byte at the head of the window starts
    typedef enum logic [3:0] {
        CLS_NOP      = 4'd0,
        CLS_INCF     = 4'd1,
        CLS_DECF     = 4'd2,
        CLS_CCF      = 4'd3,
        CLS_LDF      = 4'd4,
        CLS_LD_IMM   = 4'd5,
        CLS_JP_IMM   = 4'd6,
        CLS_PREFIX_R = 4'd7,  // 11zz_1rrr
        CLS_PREFIX_X = 4'd8,  // C7/D7/E7 plus register byte
        CLS_UNKNOWN  = 4'd15
    } op_class_t;

endpackage

//--- rtl/cpu_regs_pkg.sv
// register-file naming: operand size, write masks, register codes
// expand_reg turns a 3-bit short register into a full register-file address
package cpu_regs_pkg;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2,
        SZ_JP24 = 2'd3   // 24-bit jump target, never a register size
    } size_t;

    typedef logic [2:0] we_mask_t;   // one-hot, byte/word/long
    typedef logic [7:0] reg_code_t;

    function automatic we_mask_t size_mask(input size_t sz);
        case (sz)
            SZ_BYTE: return 3'b001;
            SZ_WORD: return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    // short codes map into the current bank at E0..FF
    function automatic reg_code_t expand_reg(input logic [2:0] r, input size_t sz);
        if (sz == SZ_BYTE) begin
            return {4'he, r[2:1], 1'b0, ~r[0]};  // odd byte for even r
        end
        if (r[2]) begin
            return {4'hf, r[1:0], 2'b00};
        end
        return {4'he, r[1:0], 2'b00};
    endfunction

endpackage

//--- rtl/ctrl_seq.sv
// instruction sequencer: phase FSM, window consumption and registered commands
// strobes last one enabled cycle, other commands hold until replaced
`timescale 1ns/100ps

module ctrl_seq (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cen,
    input  logic                                op_ok,
    input  logic [cpu_ops_pkg::OP_BYTES*8-1:0]  op,
    input  cpu_ops_pkg::op_class_t              fd_class,
    input  cpu_regs_pkg::size_t                 fd_size,
    input  cpu_regs_pkg::reg_code_t             fd_reg,
    input  logic [7:0]                          fd_imm,
    input  logic [1:0]                          fd_len,
    input  cpu_ops_pkg::alu_op_t                ex_alu_op,
    input  cpu_regs_pkg::reg_code_t             ex_src,
    input  cpu_regs_pkg::reg_code_t             ex_dst,
    input  cpu_regs_pkg::we_mask_t              ex_we,
    input  logic                                ex_use_imm3,
    input  logic                                ex_sets_flags,
    input  logic                                ex_legal,
    output logic [1:0]                          fetched,
    output cpu_regs_pkg::size_t                 latched_size,
    output cpu_regs_pkg::reg_code_t             prefix_reg,
    output logic                                pc_we,
    output logic                                rfp_we,
    output logic                                inc_rfp,
    output logic                                dec_rfp,
    output logic                                flag_we,
    output cpu_ops_pkg::alu_op_t                alu_op,
    output logic [cpu_ops_pkg::IMM_W-1:0]       alu_imm,
    output logic                                alu_smux,
    output logic                                alu_wait,
    output cpu_regs_pkg::we_mask_t              regs_we,
    output cpu_regs_pkg::reg_code_t             regs_dst,
    output cpu_regs_pkg::reg_code_t             regs_src
);
    import cpu_ops_pkg::*;
    import cpu_regs_pkg::*;

    phase_t          phase, nx_phase;
    logic            settle;            // window refilling after a fetch
    we_mask_t        keep_we, nx_keep_we, nx_regs_we;
    logic            keep_pc_we, nx_keep_pc_we;
    logic            nx_pc_we, nx_rfp_we, nx_inc, nx_dec, nx_flag_we;
    alu_op_t         nx_alu_op;
    logic [IMM_W-1:0] nx_imm;
    logic            nx_smux, nx_wait;
    size_t           nx_size;
    reg_code_t       nx_prefix, nx_dst, nx_src;

    always_comb begin
        fetched       = 2'd0;
        nx_phase      = phase;
        nx_keep_we    = keep_we;
        nx_keep_pc_we = keep_pc_we;
        nx_regs_we    = '0;
        nx_pc_we      = 1'b0;
        nx_rfp_we     = 1'b0;
        nx_inc        = 1'b0;
        nx_dec        = 1'b0;
        nx_flag_we    = 1'b0;
        nx_alu_op     = alu_op;
        nx_imm        = alu_imm;
        nx_smux       = alu_smux;
        nx_wait       = alu_wait;
        nx_size       = latched_size;
        nx_prefix     = prefix_reg;
        nx_dst        = regs_dst;
        nx_src        = regs_src;
        if (cen && op_ok && !settle) begin
            case (phase)
                FETCH: begin
                    fetched       = fd_len;
                    nx_alu_op     = ALU_NOP;
                    nx_smux       = 1'b0;
                    nx_wait       = 1'b0;
                    nx_keep_we    = '0;
                    nx_keep_pc_we = 1'b0;
                    case (fd_class)
                        CLS_INCF: nx_inc = 1'b1;
                        CLS_DECF: nx_dec = 1'b1;
                        CLS_CCF: begin
                            nx_flag_we = 1'b1;
                            nx_alu_op  = ALU_CCF;
                        end
                        CLS_LDF: begin
                            nx_rfp_we = 1'b1;
                            nx_imm    = IMM_W'(fd_imm);
                        end
                        CLS_LD_IMM: begin
                            nx_dst    = fd_reg;
                            nx_imm    = IMM_W'(fd_imm);
                            nx_alu_op = ALU_MOVE;
                            nx_smux   = 1'b1;
                            nx_size   = fd_size;
                            if (fd_size == SZ_BYTE) begin
                                nx_regs_we = size_mask(fd_size);
                            end else begin
                                nx_phase   = FILL_IMM;   // upper bytes follow
                                nx_wait    = 1'b1;
                                nx_keep_we = size_mask(fd_size);
                            end
                        end
                        CLS_JP_IMM: begin
                            nx_imm        = IMM_W'(fd_imm);
                            nx_size       = fd_size;
                            nx_phase      = FILL_IMM;
                            nx_keep_pc_we = 1'b1;
                        end
                        CLS_PREFIX_R,
                        CLS_PREFIX_X: begin
                            nx_size   = fd_size;
                            nx_prefix = fd_reg;
                            nx_phase  = EXEC;
                        end
                        default: ;   // NOP and unknown bytes
                    endcase
                end
                EXEC: begin
                    fetched    = 2'd1;
                    nx_phase   = FETCH;
                    nx_alu_op  = ex_alu_op;
                    nx_regs_we = ex_we;
                    nx_flag_we = ex_sets_flags;
                    if (ex_legal) begin
                        nx_src  = ex_src;
                        nx_dst  = ex_dst;
                        nx_smux = ex_use_imm3;
                        if (ex_use_imm3) begin
                            nx_imm = IMM_W'(op[2:0]);
                        end
                    end
                end
                FILL_IMM: begin
                    nx_phase   = FETCH;
                    nx_wait    = 1'b0;
                    nx_regs_we = keep_we;
                    nx_pc_we   = keep_pc_we;
                    case (latched_size)
                        SZ_WORD: begin
                            nx_imm = {16'd0, op[7:0], alu_imm[7:0]};
                            fetched = 2'd1;
                        end
                        SZ_LONG: begin
                            nx_imm = {op[23:0], alu_imm[7:0]};
                            fetched = 2'd3;
                        end
                        SZ_JP24: begin
                            nx_imm = {8'd0, op[15:0], alu_imm[7:0]};
                            fetched = 2'd2;
                        end
                        default: ;
                    endcase
                end
                default: nx_phase = FETCH;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            phase      <= FETCH;
            settle     <= 1'b0;
            keep_we    <= '0;
            keep_pc_we <= 1'b0;
            regs_we    <= '0;
            pc_we      <= 1'b0;
            rfp_we     <= 1'b0;
            inc_rfp    <= 1'b0;
            dec_rfp    <= 1'b0;
            flag_we    <= 1'b0;
            alu_op     <= ALU_NOP;
            alu_imm    <= '0;
            alu_smux   <= 1'b0;
            alu_wait   <= 1'b0;
        end else if (cen) begin
            phase      <= nx_phase;
            settle     <= fetched != 2'd0;
            keep_we    <= nx_keep_we;
            keep_pc_we <= nx_keep_pc_we;
            regs_we    <= nx_regs_we;
            pc_we      <= nx_pc_we;
            rfp_we     <= nx_rfp_we;
            inc_rfp    <= nx_inc;
            dec_rfp    <= nx_dec;
            flag_we    <= nx_flag_we;
            alu_op     <= nx_alu_op;
            alu_imm    <= nx_imm;
            alu_smux   <= nx_smux;
            alu_wait   <= nx_wait;
        end
    end

    // operand size and register codes for the phase that follows
    always_ff @(posedge clk) begin
        if (cen) begin
            latched_size <= nx_size;
            prefix_reg   <= nx_prefix;
            regs_dst     <= nx_dst;
            regs_src     <= nx_src;
        end
    end

endmodule

//--- rtl/exec_decode.sv
// decodes the byte after a register prefix
// prefix_reg is r, the short code in the byte is R
`timescale 1ns/100ps

module exec_decode (
    input  logic [7:0]               op,
    input  cpu_regs_pkg::size_t      size,
    input  cpu_regs_pkg::reg_code_t  prefix_reg,
    output cpu_ops_pkg::alu_op_t     alu_op,
    output cpu_regs_pkg::reg_code_t  src,
    output cpu_regs_pkg::reg_code_t  dst,
    output cpu_regs_pkg::we_mask_t   we,
    output logic                     use_imm3,
    output logic                     sets_flags,
    output logic                     legal
);
    import cpu_ops_pkg::*;
    import cpu_regs_pkg::*;

    reg_code_t short_reg;
    we_mask_t  mask;

    assign short_reg = expand_reg(op[2:0], size);
    assign mask      = size_mask(size);

    always_comb begin
        alu_op     = ALU_NOP;
        src        = prefix_reg;
        dst        = prefix_reg;
        we         = '0;
        use_imm3   = 1'b0;
        sets_flags = 1'b0;
        legal      = 1'b1;
        casez (op)
            8'b1000_1???: begin   // LD R,r
                alu_op = ALU_MOVE;
                dst    = short_reg;
                we     = mask;
            end
            8'b1001_1???: begin   // LD r,R
                alu_op = ALU_MOVE;
                src    = short_reg;
                we     = mask;
            end
            8'b1010_1???: begin   // LD r,#3
                alu_op   = ALU_MOVE;
                use_imm3 = 1'b1;
                we       = mask;
            end
            8'b1101_1???: begin   // CP r,#3
                alu_op     = ALU_CP;
                use_imm3   = 1'b1;
                sets_flags = 1'b1;
            end
            8'h06: begin
                alu_op = ALU_CPL;
                we     = mask;
            end
            8'h07: begin
                alu_op = ALU_NEG;
                we     = mask;
            end
            8'b1???_0???: begin   // two-register ALU, R op r
                dst = short_reg;
                case (op[6:4])
                    3'd0: alu_op = ALU_ADD;
                    3'd1: alu_op = ALU_ADC;
                    3'd2: alu_op = ALU_SUB;
                    3'd3: alu_op = ALU_SBC;
                    3'd4: alu_op = ALU_AND;
                    3'd5: alu_op = ALU_XOR;
                    3'd6: alu_op = ALU_OR;
                    default: alu_op = ALU_CP;
                endcase
                if (op[6:4] == 3'd7) begin
                    sets_flags = 1'b1;   // compare leaves R untouched
                end else begin
                    we = mask;
                end
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/first_byte_decode.sv
// classifies the opcode byte at the head of the window
// gives the size, register and first-phase byte count to the sequencer
`timescale 1ns/100ps

module first_byte_decode (
    input  logic [15:0]              op,
    output cpu_ops_pkg::op_class_t   op_class,
    output cpu_regs_pkg::size_t      size,
    output cpu_regs_pkg::reg_code_t  reg_code,
    output logic [7:0]               byte_imm,
    output logic [1:0]               length
);
    import cpu_ops_pkg::*;
    import cpu_regs_pkg::*;

    logic [2:0] ld_sz;   // LD R,# size field, 2..4

    assign ld_sz    = op[6:4] - 3'd2;
    assign byte_imm = op[15:8];

    always_comb begin
        op_class = CLS_UNKNOWN;
        size     = SZ_BYTE;
        reg_code = op[15:8];
        length   = 2'd1;   // unknown bytes are skipped one at a time
        casez (op[7:0])
            8'h00: begin
                op_class = CLS_NOP;
            end
            8'h0c: begin
                op_class = CLS_INCF;
            end
            8'h0d: begin
                op_class = CLS_DECF;
            end
            8'h12: begin
                op_class = CLS_CCF;
            end
            8'h17: begin
                op_class = CLS_LDF;     // RFP value in second byte
                length   = 2'd2;
            end
            8'b0010_0???,
            8'b0011_0???,
            8'b0100_0???: begin
                op_class = CLS_LD_IMM;
                size     = size_t'(ld_sz[1:0]);
                reg_code = expand_reg(op[2:0], size_t'(ld_sz[1:0]));
                length   = 2'd2;
            end
            8'b0001_101?: begin
                op_class = CLS_JP_IMM;
                size     = op[0] ? SZ_JP24 : SZ_WORD;
                length   = 2'd2;
            end
            8'hc7,
            8'hd7,
            8'he7: begin
                op_class = CLS_PREFIX_X;   // register code is the next byte
                size     = size_t'(op[5:4]);
                length   = 2'd2;
            end
            8'b11??_1???: begin
                if (op[5:4] != 2'b11) begin
                    op_class = CLS_PREFIX_R;
                    size     = size_t'(op[5:4]);
                    reg_code = expand_reg(op[2:0], size_t'(op[5:4]));
                end
            end
            default: begin
                op_class = CLS_UNKNOWN;
            end
        endcase
    end

endmodule

//--- run.sh
#!/bin/bash
# compile and run the control sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module cpu_ctrl_tb -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vcpu_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    exit 1
fi
exit 0

//--- sim/cpu_ctrl_asserts.sv
// protocol assertions, bound to the sequencer from the testbench
`timescale 1ns/100ps

module cpu_ctrl_asserts (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic [1:0] fetched,
    input logic [2:0] regs_we,
    input logic       pc_we,
    input logic       rfp_we,
    input logic       inc_rfp,
    input logic       dec_rfp,
    input logic       flag_we
);
    logic        prev_nz;        // last enabled cycle consumed bytes
    int unsigned fail_cnt = 0;   // failed assertions so far

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            prev_nz <= 1'b0;
        end else if (cen) begin
            prev_nz <= fetched != 2'd0;
        end
    end

    settle_a: assert property (@(posedge clk) disable iff (rst)
        (cen && prev_nz) |-> fetched == 2'd0)
        else begin
            fail_cnt++;
            $error("fetch during settle cycle");
        end
    we_a: assert property (@(posedge clk) disable iff (rst) $onehot0(regs_we))
        else begin
            fail_cnt++;
            $error("regs_we not one-hot");
        end
    rfp_a: assert property (@(posedge clk) disable iff (rst) !(inc_rfp && dec_rfp))
        else begin
            fail_cnt++;
            $error("inc_rfp with dec_rfp");
        end
    rst_a: assert property (@(posedge clk)
        rst |-> !(regs_we != 0 || pc_we || rfp_we || inc_rfp || dec_rfp || flag_we))
        else begin
            fail_cnt++;
            $error("strobe during reset");
        end

endmodule

//--- sim/ctrl_ref_model.svh
// reference model for the control sequencer testbench
// builds one random legal instruction into the program and queues its expected strobe
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// register address of a 3-bit short code in the current bank
function automatic reg_code_t short_to_reg(input logic [2:0] r, input int sz);
    if (sz == 0) begin
        return 8'he0 + 8'(4 * r[2:1]) + (r[0] ? 8'd0 : 8'd1);
    end
    if (r < 3'd4) begin
        return 8'he0 + 8'(4 * r);
    end
    return 8'hf0 + 8'(4 * (r - 3'd4));
endfunction

function automatic alu_op_t two_reg_op(input logic [2:0] o);
    case (o)
        3'd0: return ALU_ADD;
        3'd1: return ALU_ADC;
        3'd2: return ALU_SUB;
        3'd3: return ALU_SBC;
        3'd4: return ALU_AND;
        3'd5: return ALU_XOR;
        3'd6: return ALU_OR;
        default: return ALU_CP;
    endcase
endfunction

task automatic put_byte(input logic [7:0] b);
    prog[prog_len] = b;
    prog_len++;
endtask

task automatic gen_instr(input int idx);
    exp_t        e;
    int          kind;
    int          sz;
    int          nb;
    logic [2:0]  r;
    logic [2:0]  rr;
    logic [31:0] val;
    reg_code_t   pr;
    e.kind = K_REGS;
    e.we = '0;
    e.dst = '0;
    e.src = '0;
    e.op = ALU_NOP;
    e.imm = '0;
    e.chk_src = 1'b0;
    e.chk_imm = 1'b0;
    e.smux = 1'b0;
    e.need_wait = 1'b0;
    kind = rnd(9);
    sz = rnd(3);
    r = 3'(rnd(8));
    rr = 3'(rnd(8));
    val = $random(seed);
    case (kind)
        0: begin
            put_byte(8'h00);   // NOP, no strobe
            return;
        end
        1: begin
            put_byte(8'h0c);
            e.kind = K_INC;
        end
        2: begin
            put_byte(8'h0d);
            e.kind = K_DEC;
        end
        3: begin
            put_byte(8'h12);
            e.kind = K_FLAG;
            e.op = ALU_CCF;
        end
        4: begin
            put_byte(8'h17);
            put_byte(val[7:0]);
            e.kind = K_RFP;
            e.imm = {24'd0, val[7:0]};
            e.chk_imm = 1'b1;
        end
        5: begin
            put_byte(8'h20 + 8'(sz * 16) + 8'(r));
            nb = (sz == 0) ? 1 : (sz == 1) ? 2 : 4;
            for (int i = 0; i < nb; i++) begin
                put_byte(val[8*i +: 8]);
            end
            e.we = 3'(1 << sz);
            e.dst = short_to_reg(r, sz);
            e.op = ALU_MOVE;
            e.imm = (nb == 4) ? val : (nb == 2) ? {16'd0, val[15:0]} : {24'd0, val[7:0]};
            e.chk_imm = 1'b1;
            e.smux = 1'b1;
            e.need_wait = (sz != 0);
        end
        6: begin
            nb = (sz == 2) ? 3 : 2;   // 24 or 16 bit target
            put_byte((nb == 3) ? 8'h1b : 8'h1a);
            for (int i = 0; i < nb; i++) begin
                put_byte(val[8*i +: 8]);
            end
            e.kind = K_PC;
            e.imm = (nb == 3) ? {8'd0, val[23:0]} : {16'd0, val[15:0]};
            e.chk_imm = 1'b1;
        end
        default: begin
            if (rnd(2) == 0) begin
                put_byte(8'hc8 + 8'(sz * 16) + 8'(r));
                pr = short_to_reg(r, sz);
            end else begin
                put_byte(8'hc7 + 8'(sz * 16));
                put_byte(val[15:8]);
                pr = val[15:8];
            end
            e.we = 3'(1 << sz);
            e.src = pr;
            e.dst = pr;
            e.chk_src = 1'b1;
            e.op = ALU_MOVE;
            case (rnd(7))
                0: begin
                    put_byte(8'h88 + 8'(rr));   // LD R,r
                    e.dst = short_to_reg(rr, sz);
                end
                1: begin
                    put_byte(8'h98 + 8'(rr));   // LD r,R
                    e.src = short_to_reg(rr, sz);
                end
                2: begin
                    put_byte(8'ha8 + 8'(rr));   // LD r,#3
                    e.imm = {29'd0, rr};
                    e.chk_imm = 1'b1;
                    e.smux = 1'b1;
                end
                3: begin
                    put_byte(8'hd8 + 8'(rr));   // CP r,#3
                    e.kind = K_FLAG;
                    e.op = ALU_CP;
                    e.imm = {29'd0, rr};
                    e.chk_imm = 1'b1;
                end
                4: begin
                    put_byte(8'h06);
                    e.op = ALU_CPL;
                end
                5: begin
                    put_byte(8'h07);
                    e.op = ALU_NEG;
                end
                default: begin
                    put_byte(8'h80 + 8'(val[18:16] * 16) + 8'(rr));
                    e.op = two_reg_op(val[18:16]);
                    e.dst = short_to_reg(rr, sz);
                    if (e.op == ALU_CP) begin
                        e.kind = K_FLAG;
                    end
                end
            endcase
        end
    endcase
    exp_q.push_back(e);
    name_q.push_back($sformatf("instr %0d class %0d", idx, kind));
endtask

`endif

//--- sim/cpu_ctrl_tb.sv
// testbench for the control sequencer top level
// random program from a fixed seed, window model and strobe checks against a queued model
`timescale 1ns/100ps

module cpu_ctrl_tb;
    import cpu_ops_pkg::*;
    import cpu_regs_pkg::*;

    localparam int N_INSTR = 200;
    localparam int K_REGS = 0;
    localparam int K_PC = 1;
    localparam int K_RFP = 2;
    localparam int K_INC = 3;
    localparam int K_DEC = 4;
    localparam int K_FLAG = 5;

    typedef struct {
        int          kind;
        we_mask_t    we;
        reg_code_t   dst;
        reg_code_t   src;
        alu_op_t     op;
        logic [31:0] imm;
        bit          chk_src;
        bit          chk_imm;
        bit          smux;
        bit          need_wait;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [31:0] op;
    logic        op_ok;
    logic [1:0]  fetched;
    logic        pc_we, rfp_we, inc_rfp, dec_rfp, flag_we;
    alu_op_t     alu_op;
    logic [31:0] alu_imm;
    logic        alu_smux, alu_wait;
    we_mask_t    regs_we;
    reg_code_t   regs_dst, regs_src;

    int          seed = 76;
    logic [7:0]  prog [0:2047];
    int          prog_len = 0;
    int          pos = 0;
    int          pend = 0;
    int          sum_fetched = 0;
    bit          seen_ok = 0;
    bit          saw_wait = 0;
    exp_t        exp_q [$];
    string       name_q [$];

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    `include "ctrl_ref_model.svh"

    cpu_ctrl cpu_ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .op_ok    (op_ok),
        .fetched  (fetched),
        .pc_we    (pc_we),
        .rfp_we   (rfp_we),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp),
        .flag_we  (flag_we),
        .alu_op   (alu_op),
        .alu_imm  (alu_imm),
        .alu_smux (alu_smux),
        .alu_wait (alu_wait),
        .regs_we  (regs_we),
        .regs_dst (regs_dst),
        .regs_src (regs_src)
    );

    bind ctrl_seq cpu_ctrl_asserts cpu_ctrl_asserts_inst (
        .clk (clk), .rst (rst), .cen (cen), .fetched (fetched), .regs_we (regs_we),
        .pc_we (pc_we), .rfp_we (rfp_we), .inc_rfp (inc_rfp), .dec_rfp (dec_rfp),
        .flag_we (flag_we)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input string field,
                            input logic [31:0] expv, input logic [31:0] actv);
        fail_run($sformatf("MISMATCH %s %s: expected %h actual %h", name, field, expv, actv));
    endtask

    task automatic check_regs(input string name, input exp_t e);
        if (regs_we !== e.we) mismatch(name, "regs_we", 32'(e.we), 32'(regs_we));
        if (regs_dst !== e.dst) mismatch(name, "regs_dst", 32'(e.dst), 32'(regs_dst));
        if (e.chk_src && regs_src !== e.src) mismatch(name, "regs_src", 32'(e.src), 32'(regs_src));
        if (alu_op !== e.op) mismatch(name, "alu_op", 32'(e.op), 32'(alu_op));
        if (alu_smux !== e.smux) mismatch(name, "alu_smux", 32'(e.smux), 32'(alu_smux));
        if (e.chk_imm && alu_imm !== e.imm) mismatch(name, "alu_imm", e.imm, alu_imm);
        if (e.need_wait && !saw_wait) fail_run($sformatf("%s: alu_wait never rose", name));
    endtask

    task automatic check_pc(input string name, input logic [31:0] imm);
        if (alu_imm !== imm) mismatch(name, "jump target", imm, alu_imm);
    endtask

    task automatic check_rfp(input string name, input int kind, input logic [31:0] imm);
        if (kind == K_RFP && alu_imm !== imm) mismatch(name, "rfp value", imm, alu_imm);
    endtask

    task automatic check_flags(input string name, input alu_op_t expop, input exp_t e);
        if (alu_op !== expop) mismatch(name, "alu_op", 32'(expop), 32'(alu_op));
        if (e.chk_imm && alu_imm !== e.imm) mismatch(name, "alu_imm", e.imm, alu_imm);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(N_INSTR * 8 * 5 * 100 + 16 * 100);
        $display("timeout: the program did not complete in time");
        $display("Errors found");
        $fatal(1);
    end

    // collector, samples in mid-cycle where outputs and inputs are stable
    always @(negedge clk) begin
        exp_t  e;
        string nm;
        int    act;
        int    nstb;
        if (cpu_ctrl_inst.ctrl_seq_inst.cpu_ctrl_asserts_inst.fail_cnt != 0) begin
            fail_run("a protocol assertion on the sequencer failed");
        end
        if (alu_wait) saw_wait = 1;
        if (!seen_ok && !op_ok && (fetched != 0 || regs_we != 0 || pc_we || rfp_we ||
                inc_rfp || dec_rfp || flag_we || alu_op != ALU_NOP)) begin
            fail_run("outputs active before op_ok was ever high");
        end
        if (op_ok) seen_ok = 1;
        if (!rst && cen) begin
            pend = fetched;
            nstb = int'(regs_we != 0) + pc_we + rfp_we + inc_rfp + dec_rfp + flag_we;
            act = (regs_we != 0) ? K_REGS : pc_we ? K_PC : rfp_we ? K_RFP :
                  inc_rfp ? K_INC : dec_rfp ? K_DEC : K_FLAG;
            if (nstb > 1) fail_run("more than one strobe in the same cycle");
            if (nstb == 1) begin
                if (exp_q.size() == 0) fail_run("strobe seen with no instruction pending");
                e = exp_q.pop_front();
                nm = name_q.pop_front();
                if (act != e.kind) mismatch(nm, "strobe kind", e.kind, act);
                case (e.kind)
                    K_REGS: check_regs(nm, e);
                    K_PC: check_pc(nm, e.imm);
                    K_FLAG: check_flags(nm, e.op, e);
                    default: check_rfp(nm, e.kind, e.imm);
                endcase
                saw_wait = 0;
            end
        end
    end

    initial begin
        for (int i = 0; i < 2048; i++) begin
            prog[i] = 8'(i ^ (i >> 8));   // bytes past the program
        end
        for (int i = 0; i < N_INSTR; i++) begin
            gen_instr(i);
        end
        rst = 1'b1;
        cen = 1'b1;
        op_ok = 1'b0;
        op = {prog[3], prog[2], prog[1], prog[0]};
        repeat (16) @(posedge clk);
        #10 rst = 1'b0;
        fork
            forever begin
                @(posedge clk);
                #10;
                pos += pend;
                sum_fetched += pend;
                pend = 0;
                op = {prog[pos+3], prog[pos+2], prog[pos+1], prog[pos]};
                cen = (rnd(5) != 0);
                op_ok = (pos < prog_len) && (rnd(5) != 0);
            end
        join_none
        while (!(pos >= prog_len && exp_q.size() == 0)) @(posedge clk);
        repeat (6) @(posedge clk);   // catch late extra strobes
        if (sum_fetched == prog_len && exp_q.size() == 0) begin
            $display("No errors");
        end else begin
            $display("consumed %0d bytes of a %0d byte program", sum_fetched, prog_len);
            $display("Errors found");
        end
        $finish;
    end

endmodule
